/* sim.f */
source/riscv_pkg.sv
source/riscv_regfile.sv
source/riscv_hart_multicycle.sv
source/port_switch.sv
source/riscv_hart_top.sv
+incdir+verif
verif/tb_riscv_hart_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
	--top-module tb_riscv_hart_top -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

/* verif/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// --------------------
// encoders for the RV32I base formats
function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
endfunction

// sw only, funct3 010
function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
	input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
	return {imm, rd, riscv_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OPC_JAL};
endfunction

// ebreak is SYSTEM with imm 1
function automatic logic [31:0] enc_ebreak();
	return enc_i(riscv_pkg::OPC_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h001);
endfunction

// --------------------
// expected constants shared by the tests
localparam logic [31:0] PER_READ_VALUE = 32'hCAFE_0123;
localparam logic [31:0] DATA_BASE = 32'h0000_0100;
localparam int TOTAL_INSTR = 48;

// lui/addi/add/sub/and/or, then six stores
task automatic build_arith();
	prog.delete();
	prog.push_back(enc_u(5'd1, 20'h12345));
	prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'h678));
	prog.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
	prog.push_back(enc_r(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
	prog.push_back(enc_r(7'h00, 3'b111, 5'd5, 5'd3, 5'd4));
	prog.push_back(enc_r(7'h00, 3'b110, 5'd6, 5'd2, 5'd1));
	prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h100));
	for (int r = 1; r <= 6; r++) begin
		prog.push_back(enc_s(5'd10, 5'(r), 12'((r - 1) * 4)));
	end
	prog.push_back(enc_ebreak());
endtask

`endif

/* verif/tb_riscv_hart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_hart_top;

	logic clock_i;
	logic rst_n_i;
	logic [3:0] exception_bus_o;
	logic [31:0] inst_addr_o;
	logic [31:0] inst_word_o;
	logic mem_req0_o;
	logic [31:0] mem_add0_o;
	logic [31:0] mem_data0_i;
	logic mem_done0_i;
	logic mem_req1_o;
	logic mem_rw1_o;
	logic [31:0] mem_add1_o;
	logic [31:0] mem_data1_o;
	logic [31:0] mem_data1_i;
	logic mem_done1_i;
	logic per_req_o;
	logic per_rw_o;
	logic [31:0] per_add_o;
	logic [31:0] per_data_o;
	logic [31:0] per_data_i;

	// models and bookkeeping
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] prog [$];
	logic [31:0] trace_pc [$];
	riscv_pkg::instr_u trace_word [$];
	logic [31:0] rng_state;
	int inst_wait;
	int data_wait;
	int fetches;
	int mem1_requests;
	int mem1_writes;
	int per_writes;
	int per_reads;
	logic [31:0] per_wr_addr;
	logic [31:0] per_wr_data;
	logic [31:0] per_rd_addr;
	int errors;
	int cycle_count;

	`include "tb_programs.svh"

	// reset overhead added on top of the per-instruction bound
	localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 7 * 2 + 7 * 20;

	riscv_hart_top riscv_hart_top_inst (
		.clock_i (clock_i), .rst_n_i (rst_n_i), .exception_bus_o (exception_bus_o),
		.inst_addr_o (inst_addr_o), .inst_word_o (inst_word_o),
		.mem_req0_o (mem_req0_o), .mem_add0_o (mem_add0_o),
		.mem_data0_i (mem_data0_i), .mem_done0_i (mem_done0_i),
		.mem_req1_o (mem_req1_o), .mem_rw1_o (mem_rw1_o), .mem_add1_o (mem_add1_o),
		.mem_data1_o (mem_data1_o), .mem_data1_i (mem_data1_i), .mem_done1_i (mem_done1_i),
		.per_req_o (per_req_o), .per_rw_o (per_rw_o), .per_add_o (per_add_o),
		.per_data_o (per_data_o), .per_data_i (per_data_i)
	);

	initial begin
		clock_i = 1'b0;
		forever #5 clock_i = ~clock_i;
	end

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// response delay of 1 to 4 cycles
	function int draw_delay();
		rng_state = xorshift(rng_state);
		return 1 + int'(rng_state % 4);
	endfunction

	// --------------------
	// instruction memory, logs the trace once a fetch lands
	always @(negedge clock_i) begin
		if (!rst_n_i) begin
			mem_done0_i = 1'b0;
			inst_wait = 0;
		end else if (mem_done0_i) begin
			mem_done0_i = 1'b0;
			trace_pc.push_back(inst_addr_o);
			trace_word.push_back(inst_word_o);
		end else if (mem_req0_o) begin
			if (inst_wait == 0) begin
				inst_wait = draw_delay();
				fetches++;
			end
			inst_wait--;
			if (inst_wait == 0) begin
				mem_done0_i = 1'b1;
				mem_data0_i = imem[mem_add0_o[9:2]];
			end
		end
	end

	// data memory
	always @(negedge clock_i) begin
		if (!rst_n_i) begin
			mem_done1_i = 1'b0;
			data_wait = 0;
		end else if (mem_done1_i) begin
			mem_done1_i = 1'b0;
		end else if (mem_req1_o) begin
			if (data_wait == 0) begin
				data_wait = draw_delay();
				mem1_requests++;
			end
			data_wait--;
			if (data_wait == 0) begin
				mem_done1_i = 1'b1;
				if (mem_rw1_o) begin
					dmem[mem_add1_o[9:2]] = mem_data1_o;
					mem1_writes++;
				end else begin
					mem_data1_i = dmem[mem_add1_o[9:2]];
				end
			end
		end
	end

	// peripheral strobe log
	always @(negedge clock_i) begin
		if (rst_n_i && per_req_o) begin
			if (per_rw_o) begin
				per_wr_addr = per_add_o;
				per_wr_data = per_data_o;
				per_writes++;
			end else begin
				per_rd_addr = per_add_o;
				per_reads++;
			end
		end
	end

	// --------------------
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_instr(input string name, input riscv_pkg::instr_u got,
		input riscv_pkg::instr_u exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%08h (opcode 0x%02h) expected 0x%08h",
				name, got, got.r.opcode, exp);
		end
	endtask

	task automatic check_exception(input string name, input logic [3:0] got,
		input logic [3:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
		end
	endtask

	// reset, load the program in prog, release and run to the first exception
	task automatic run_program();
		@(negedge clock_i);
		rst_n_i = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'hBAD0_0000 | (32'(i) << 2);
			dmem[i] = 32'h5EED_0000 ^ (32'(i) << 2);
		end
		foreach (prog[i]) begin
			imem[i] = prog[i];
		end
		trace_pc.delete();
		trace_word.delete();
		fetches = 0;
		mem1_requests = 0;
		mem1_writes = 0;
		per_writes = 0;
		per_reads = 0;
		per_wr_addr = '0;
		per_wr_data = '0;
		per_rd_addr = '0;
		repeat (8) @(negedge clock_i);
		rst_n_i = 1'b1;
		while (exception_bus_o == riscv_pkg::EXC_NONE) begin
			@(negedge clock_i);
		end
	endtask

	// --------------------
	task automatic test_arith();
		logic [31:0] exp [6];
		build_arith();
		run_program();
		exp[0] = 32'h12345 << 12;
		exp[1] = 32'h678;
		exp[2] = exp[0] + exp[1];
		exp[3] = exp[1] - exp[0];
		exp[4] = exp[2] & exp[3];
		exp[5] = exp[1] | exp[0];
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_BREAK);
		check_word("mem1 write count", mem1_writes, 6);
		for (int i = 0; i < 6; i++) begin
			check_word("dmem arith result", dmem[(DATA_BASE >> 2) + i], exp[i]);
		end
	endtask

	task automatic test_round_trip();
		prog.delete();
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h100));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h2A5));
		prog.push_back(enc_s(5'd10, 5'd1, 12'h000));
		prog.push_back(enc_i(riscv_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd10, 12'h000));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd2, 5'd2, 12'h001));
		prog.push_back(enc_s(5'd10, 5'd2, 12'h008));
		prog.push_back(enc_ebreak());
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_BREAK);
		check_word("dmem[0x100]", dmem[(DATA_BASE >> 2)], 32'h2A5);
		check_word("dmem[0x108]", dmem[(DATA_BASE >> 2) + 2], 32'h2A6);
	endtask

	task automatic test_peripheral();
		prog.delete();
		prog.push_back(enc_u(5'd10, 20'hF0000));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h05A));
		prog.push_back(enc_s(5'd10, 5'd1, 12'h010));
		prog.push_back(enc_i(riscv_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd10, 12'h020));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd11, 5'd0, 12'h100));
		prog.push_back(enc_s(5'd11, 5'd2, 12'h000));
		prog.push_back(enc_ebreak());
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_BREAK);
		check_word("per write count", per_writes, 1);
		check_word("per read count", per_reads, 1);
		// write strobe carries address and data, read strobe its address
		check_word("per_add_o write", per_wr_addr, 32'hF000_0010);
		check_word("per_data_o write", per_wr_data, 32'h5A);
		check_word("per_add_o read", per_rd_addr, 32'hF000_0020);
		check_word("mem_req1 count", mem1_requests, 1);
		check_word("dmem[0x100]", dmem[(DATA_BASE >> 2)], PER_READ_VALUE);
	endtask

	task automatic test_control_flow();
		logic [31:0] exp_pc [8];
		exp_pc = '{32'h00, 32'h04, 32'h08, 32'h10, 32'h14, 32'h20, 32'h24, 32'h28};
		prog.delete();
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h005));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'h005));
		prog.push_back(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd3, 5'd0, 12'h001));
		prog.push_back(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
		prog.push_back(enc_j(5'd5, 21'd12));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd3, 5'd0, 12'h002));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd3, 5'd0, 12'h003));
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h100));
		prog.push_back(enc_s(5'd10, 5'd5, 12'h000));
		prog.push_back(enc_ebreak());
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_BREAK);
		check_word("trace length", trace_pc.size(), 8);
		for (int i = 0; i < 8 && i < trace_pc.size(); i++) begin
			check_word("inst_addr_o", trace_pc[i], exp_pc[i]);
			check_instr("inst_word_o", trace_word[i], prog[exp_pc[i] >> 2]);
		end
		// link of jal at 0x14
		check_word("dmem[0x100]", dmem[(DATA_BASE >> 2)], 32'h18);
	endtask

	task automatic test_illegal();
		int fetched;
		prog.delete();
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h001));
		prog.push_back(32'h0000_007F);
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'h001));
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_ILLEGAL);
		check_word("inst_addr_o", inst_addr_o, 32'h4);
		check_instr("inst_word_o", inst_word_o, 32'h0000_007F);
		fetched = fetches;
		repeat (10) @(negedge clock_i);
		check_word("mem_req0 count after halt", fetches, fetched);
	endtask

	task automatic test_misaligned();
		prog.delete();
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h102));
		prog.push_back(enc_i(riscv_pkg::OPC_LOAD, 3'b010, 5'd1, 5'd10, 12'h000));
		prog.push_back(enc_ebreak());
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_MISALIGNED_DATA);
		check_word("mem_req1 count", mem1_requests, 0);
		// jal to 0x4 + 6
		prog.delete();
		prog.push_back(enc_i(riscv_pkg::OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h001));
		prog.push_back(enc_j(5'd0, 21'd6));
		prog.push_back(enc_ebreak());
		run_program();
		check_exception("exception_bus_o", exception_bus_o, riscv_pkg::EXC_MISALIGNED_FETCH);
		check_word("inst_addr_o", inst_addr_o, 32'h4);
	endtask

	// --------------------
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock_i);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d", errors);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst_n_i = 1'b0;
		mem_done0_i = 1'b0;
		mem_done1_i = 1'b0;
		mem_data0_i = '0;
		mem_data1_i = '0;
		per_data_i = PER_READ_VALUE;
		rng_state = 32'hf40e;
		errors = 0;
		test_arith();
		test_round_trip();
		test_peripheral();
		test_control_flow();
		test_illegal();
		test_misaligned();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/riscv_hart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_hart_top (
	// system
	input  wire                        clock_i,
	input  wire                        rst_n_i,
	output logic [3:0]                 exception_bus_o,
	output logic [riscv_pkg::XLEN-1:0] inst_addr_o,
	output logic [riscv_pkg::XLEN-1:0] inst_word_o,
	// instruction port, read only
	output logic                       mem_req0_o,
	output logic [riscv_pkg::XLEN-1:0] mem_add0_o,
	input  wire  [riscv_pkg::XLEN-1:0] mem_data0_i,
	input  wire                        mem_done0_i,
	// data port to internal memory
	output logic                       mem_req1_o,
	output logic                       mem_rw1_o,
	output logic [riscv_pkg::XLEN-1:0] mem_add1_o,
	output logic [riscv_pkg::XLEN-1:0] mem_data1_o,
	input  wire  [riscv_pkg::XLEN-1:0] mem_data1_i,
	input  wire                        mem_done1_i,
	// peripheral port
	output logic                       per_req_o,
	output logic                       per_rw_o,
	output logic [riscv_pkg::XLEN-1:0] per_add_o,
	output logic [riscv_pkg::XLEN-1:0] per_data_o,
	input  wire  [riscv_pkg::XLEN-1:0] per_data_i
);

	// --------------------
	// hart data references into the switch
	logic hart_data_req;
	logic hart_data_rw;
	logic hart_data_done;
	logic [riscv_pkg::XLEN-1:0] hart_data_add;
	logic [riscv_pkg::XLEN-1:0] hart_data_wdata;
	logic [riscv_pkg::XLEN-1:0] hart_data_rdata;

	riscv_hart_multicycle hart_inst (
		.clock_i      (clock_i),
		.rst_n_i      (rst_n_i),
		// instruction fetch
		.inst_data_i  (mem_data0_i),
		.inst_done_i  (mem_done0_i),
		.inst_req_o   (mem_req0_o),
		.inst_addr_o  (mem_add0_o),
		// data references
		.data_data_i  (hart_data_rdata),
		.data_done_i  (hart_data_done),
		.data_req_o   (hart_data_req),
		.data_wren_o  (hart_data_rw),
		.data_addr_o  (hart_data_add),
		.data_data_o  (hart_data_wdata),
		// trace of the instruction being executed
		.trace_pc_o   (inst_addr_o),
		.trace_word_o (inst_word_o),
		.exception_o  (exception_bus_o)
	);

	port_switch peripheral_switch_inst (
		.clock_i           (clock_i),
		.rst_n_i           (rst_n_i),
		.core_req_i        (hart_data_req),
		.core_wren_i       (hart_data_rw),
		.core_addr_i       (hart_data_add),
		.core_data_i       (hart_data_wdata),
		.core_done_o       (hart_data_done),
		.core_data_o       (hart_data_rdata),
		// internal memory
		.memory_done_i     (mem_done1_i),
		.memory_data_i     (mem_data1_i),
		.memory_req_o      (mem_req1_o),
		.memory_wren_o     (mem_rw1_o),
		.memory_addr_o     (mem_add1_o),
		.memory_data_o     (mem_data1_o),
		// peripherals
		.peripheral_data_i (per_data_i),
		.peripheral_req_o  (per_req_o),
		.peripheral_wren_o (per_rw_o),
		.peripheral_addr_o (per_add_o),
		.peripheral_data_o (per_data_o)
	);

endmodule

`default_nettype wire

/* source/port_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module port_switch (
	input  wire                        clock_i,
	input  wire                        rst_n_i,
	// hart side
	input  wire                        core_req_i,
	input  wire                        core_wren_i,
	input  wire  [riscv_pkg::XLEN-1:0] core_addr_i,
	input  wire  [riscv_pkg::XLEN-1:0] core_data_i,
	output logic                       core_done_o,
	output logic [riscv_pkg::XLEN-1:0] core_data_o,
	// internal memory side
	input  wire                        memory_done_i,
	input  wire  [riscv_pkg::XLEN-1:0] memory_data_i,
	output logic                       memory_req_o,
	output logic                       memory_wren_o,
	output logic [riscv_pkg::XLEN-1:0] memory_addr_o,
	output logic [riscv_pkg::XLEN-1:0] memory_data_o,
	// peripheral side, no done of its own
	input  wire  [riscv_pkg::XLEN-1:0] peripheral_data_i,
	output logic                       peripheral_req_o,
	output logic                       peripheral_wren_o,
	output logic [riscv_pkg::XLEN-1:0] peripheral_addr_o,
	output logic [riscv_pkg::XLEN-1:0] peripheral_data_o
);

	// reference in flight and its latched route
	logic busy_q;
	logic route_periph_q;
	logic addr_periph;
	logic sel_periph;

	// --------------------
	// route decode on bits 31..28
	assign addr_periph = (core_addr_i[riscv_pkg::XLEN-1 -: 4] == riscv_pkg::PERIPH_REGION);
	// first cycle decodes live, later cycles use the latch
	assign sel_periph = busy_q ? route_periph_q : addr_periph;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			route_periph_q <= 1'b0;
		end else begin
			busy_q <= core_req_i && !core_done_o;
			if (core_req_i && !busy_q) begin
				route_periph_q <= addr_periph;
			end
		end
	end

	// memory path straight through
	assign memory_req_o = core_req_i && !sel_periph;
	assign memory_wren_o = core_wren_i && !sel_periph;
	assign memory_addr_o = core_addr_i;
	assign memory_data_o = core_data_i;

	// peripheral strobe in the first cycle only
	assign peripheral_req_o = core_req_i && !busy_q && addr_periph;
	assign peripheral_wren_o = core_wren_i && sel_periph;
	assign peripheral_addr_o = core_addr_i;
	assign peripheral_data_o = core_data_i;

	// --------------------
	// peripheral done is the cycle after the strobe
	assign core_done_o = sel_periph ? busy_q : memory_done_i;
	assign core_data_o = sel_periph ? peripheral_data_i : memory_data_i;

	a_one_target: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(memory_req_o && peripheral_req_o));

endmodule

`default_nettype wire

/* source/riscv_hart_multicycle.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_hart_multicycle (
	input  wire                        clock_i,
	input  wire                        rst_n_i,
	// instruction references
	input  wire  [riscv_pkg::XLEN-1:0] inst_data_i,
	input  wire                        inst_done_i,
	output logic                       inst_req_o,
	output logic [riscv_pkg::XLEN-1:0] inst_addr_o,
	// data references
	input  wire  [riscv_pkg::XLEN-1:0] data_data_i,
	input  wire                        data_done_i,
	output logic                       data_req_o,
	output logic                       data_wren_o,
	output logic [riscv_pkg::XLEN-1:0] data_addr_o,
	output logic [riscv_pkg::XLEN-1:0] data_data_o,
	// trace and status
	output logic [riscv_pkg::XLEN-1:0] trace_pc_o,
	output logic [riscv_pkg::XLEN-1:0] trace_word_o,
	output logic [3:0]                 exception_o
);

	// sequencer and architectural state
	logic [riscv_pkg::STATE_W-1:0] state_q;
	logic [riscv_pkg::XLEN-1:0] pc_q;
	logic [riscv_pkg::XLEN-1:0] trace_pc_q;
	riscv_pkg::instr_u instr_q;
	logic [3:0] exc_q;

	// operands latched in decode, results latched in execute
	logic [riscv_pkg::XLEN-1:0] rs1_q;
	logic [riscv_pkg::XLEN-1:0] rs2_q;
	logic [riscv_pkg::XLEN-1:0] imm_q;
	logic [riscv_pkg::XLEN-1:0] result_q;
	logic [riscv_pkg::XLEN-1:0] next_pc_q;

	logic [6:0] opcode;
	logic [riscv_pkg::XLEN-1:0] rs1_data;
	logic [riscv_pkg::XLEN-1:0] rs2_data;
	logic [riscv_pkg::XLEN-1:0] imm_dec;
	logic illegal;
	logic is_ebreak;
	logic is_mem;
	logic writes_rd;
	logic wr_en;

	logic [riscv_pkg::XLEN-1:0] alu_a;
	logic [riscv_pkg::XLEN-1:0] alu_b;
	logic [riscv_pkg::XLEN-1:0] alu_out;
	logic [riscv_pkg::XLEN-1:0] target;
	logic branch_taken;
	logic redirect;

	assign opcode = instr_q.r.opcode;
	assign is_mem = (opcode == riscv_pkg::OPC_LOAD) || (opcode == riscv_pkg::OPC_STORE);
	assign writes_rd = (opcode == riscv_pkg::OPC_LUI) || (opcode == riscv_pkg::OPC_OPIMM)
		|| (opcode == riscv_pkg::OPC_OP) || (opcode == riscv_pkg::OPC_LOAD)
		|| (opcode == riscv_pkg::OPC_JAL);
	assign wr_en = (state_q == riscv_pkg::ST_WRITEBACK) && writes_rd;

	riscv_regfile regfile_inst (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (instr_q.r.rs1),
		.rs2_addr_i (instr_q.r.rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_en_i    (wr_en),
		.wr_addr_i  (instr_q.r.rd),
		.wr_data_i  (result_q)
	);

	// --------------------
	// decode, immediates by format view
	always_comb begin
		imm_dec = '0;
		case (opcode)
			riscv_pkg::OPC_LUI: imm_dec = {instr_q.u.imm_31_12, 12'b0};
			riscv_pkg::OPC_OPIMM, riscv_pkg::OPC_LOAD:
				imm_dec = {{20{instr_q.i.imm_11_0[11]}}, instr_q.i.imm_11_0};
			riscv_pkg::OPC_STORE:
				imm_dec = {{20{instr_q.s.imm_11_5[6]}}, instr_q.s.imm_11_5, instr_q.s.imm_4_0};
			riscv_pkg::OPC_BRANCH:
				imm_dec = {{19{instr_q.b.imm_12}}, instr_q.b.imm_12, instr_q.b.imm_11,
					instr_q.b.imm_10_5, instr_q.b.imm_4_1, 1'b0};
			riscv_pkg::OPC_JAL:
				imm_dec = {{11{instr_q.j.imm_20}}, instr_q.j.imm_20, instr_q.j.imm_19_12,
					instr_q.j.imm_11, instr_q.j.imm_10_1, 1'b0};
			default: imm_dec = '0;
		endcase
	end

	// legality of opcode and funct fields
	always_comb begin
		illegal = 1'b0;
		is_ebreak = 1'b0;
		case (opcode)
			riscv_pkg::OPC_LUI, riscv_pkg::OPC_JAL: illegal = 1'b0;
			riscv_pkg::OPC_OPIMM: illegal = (instr_q.i.funct3 != riscv_pkg::F3_ADD_SUB);
			riscv_pkg::OPC_OP: begin
				case (instr_q.r.funct3)
					riscv_pkg::F3_ADD_SUB: illegal = (instr_q.r.funct7 != riscv_pkg::F7_BASE)
						&& (instr_q.r.funct7 != riscv_pkg::F7_SUB);
					riscv_pkg::F3_OR, riscv_pkg::F3_AND:
						illegal = (instr_q.r.funct7 != riscv_pkg::F7_BASE);
					default: illegal = 1'b1;
				endcase
			end
			riscv_pkg::OPC_LOAD: illegal = (instr_q.i.funct3 != riscv_pkg::F3_WORD);
			riscv_pkg::OPC_STORE: illegal = (instr_q.s.funct3 != riscv_pkg::F3_WORD);
			riscv_pkg::OPC_BRANCH: illegal = (instr_q.b.funct3 != riscv_pkg::F3_BEQ)
				&& (instr_q.b.funct3 != riscv_pkg::F3_BNE);
			riscv_pkg::OPC_SYSTEM: begin
				is_ebreak = (instr_q == riscv_pkg::INSTR_EBREAK);
				illegal = !is_ebreak;
			end
			default: illegal = 1'b1;
		endcase
	end

	// --------------------
	// execute, one ALU shared by all ops
	// lui adds to zero, jal forms the link pc+4
	assign alu_a = (opcode == riscv_pkg::OPC_LUI) ? '0 :
		(opcode == riscv_pkg::OPC_JAL) ? pc_q : rs1_q;
	assign alu_b = (opcode == riscv_pkg::OPC_OP) ? rs2_q :
		(opcode == riscv_pkg::OPC_JAL) ? 32'd4 : imm_q;

	always_comb begin
		alu_out = alu_a + alu_b;
		if (opcode == riscv_pkg::OPC_OP) begin
			case (instr_q.r.funct3)
				riscv_pkg::F3_OR: alu_out = alu_a | alu_b;
				riscv_pkg::F3_AND: alu_out = alu_a & alu_b;
				default: begin
					if (instr_q.r.funct7 == riscv_pkg::F7_SUB) begin
						alu_out = alu_a - alu_b;
					end
				end
			endcase
		end
	end

	// branch/jump target, bne inverts the compare
	assign target = pc_q + imm_q;
	assign branch_taken = (opcode == riscv_pkg::OPC_BRANCH)
		&& ((rs1_q == rs2_q) ^ (instr_q.b.funct3 == riscv_pkg::F3_BNE));
	assign redirect = branch_taken || (opcode == riscv_pkg::OPC_JAL);

	// --------------------
	// sequencer
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= riscv_pkg::ST_IDLE;
			pc_q <= riscv_pkg::RESET_PC;
			trace_pc_q <= riscv_pkg::RESET_PC;
			instr_q <= '0;
			exc_q <= riscv_pkg::EXC_NONE;
		end else begin
			case (state_q)
				riscv_pkg::ST_IDLE: state_q <= riscv_pkg::ST_FETCH;
				riscv_pkg::ST_FETCH: begin
					if (inst_done_i) begin
						instr_q <= inst_data_i;
						trace_pc_q <= pc_q;
						state_q <= riscv_pkg::ST_DECODE;
					end
				end
				riscv_pkg::ST_DECODE: begin
					if (illegal) begin
						exc_q <= riscv_pkg::EXC_ILLEGAL;
						state_q <= riscv_pkg::ST_HALT;
					end else if (is_ebreak) begin
						exc_q <= riscv_pkg::EXC_BREAK;
						state_q <= riscv_pkg::ST_HALT;
					end else begin
						state_q <= riscv_pkg::ST_EXECUTE;
					end
				end
				riscv_pkg::ST_EXECUTE: begin
					// alignment checked before any reference leaves
					if (is_mem && (alu_out[1:0] != 2'b00)) begin
						exc_q <= riscv_pkg::EXC_MISALIGNED_DATA;
						state_q <= riscv_pkg::ST_HALT;
					end else if (redirect && (target[1:0] != 2'b00)) begin
						exc_q <= riscv_pkg::EXC_MISALIGNED_FETCH;
						state_q <= riscv_pkg::ST_HALT;
					end else if (is_mem) begin
						state_q <= riscv_pkg::ST_MEMORY;
					end else begin
						state_q <= riscv_pkg::ST_WRITEBACK;
					end
				end
				riscv_pkg::ST_MEMORY: begin
					if (data_done_i) begin
						state_q <= riscv_pkg::ST_WRITEBACK;
					end
				end
				riscv_pkg::ST_WRITEBACK: begin
					pc_q <= next_pc_q;
					state_q <= riscv_pkg::ST_FETCH;
				end
				// halted until reset
				default: state_q <= riscv_pkg::ST_HALT;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clock_i) begin
		if (state_q == riscv_pkg::ST_DECODE) begin
			rs1_q <= rs1_data;
			rs2_q <= rs2_data;
			imm_q <= imm_dec;
		end
		if (state_q == riscv_pkg::ST_EXECUTE) begin
			result_q <= alu_out;
			next_pc_q <= redirect ? target : pc_q + 32'd4;
		end
		// load data replaces the address once the reference is done
		if ((state_q == riscv_pkg::ST_MEMORY) && data_done_i && !data_wren_o) begin
			result_q <= data_data_i;
		end
	end

	// --------------------
	// ports
	assign inst_req_o = (state_q == riscv_pkg::ST_FETCH);
	assign inst_addr_o = pc_q;
	assign data_req_o = (state_q == riscv_pkg::ST_MEMORY);
	assign data_wren_o = (opcode == riscv_pkg::OPC_STORE);
	assign data_addr_o = result_q;
	assign data_data_o = rs2_q;
	assign trace_pc_o = trace_pc_q;
	assign trace_word_o = instr_q;
	assign exception_o = exc_q;

	// one reference in flight at a time
	a_one_ref: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(inst_req_o && data_req_o));
	// req held with a stable address until done
	a_inst_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		inst_req_o && !inst_done_i |=> inst_req_o && $stable(inst_addr_o));
	a_data_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		data_req_o && !data_done_i |=> data_req_o && $stable(data_addr_o));

endmodule

`default_nettype wire

/* source/riscv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile (
	input  wire                              clock_i,
	input  wire                              rst_n_i,
	// read ports
	input  wire  [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input  wire  [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
	output logic [riscv_pkg::XLEN-1:0]       rs2_data_o,
	// write port
	input  wire                              wr_en_i,
	input  wire  [riscv_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input  wire  [riscv_pkg::XLEN-1:0]       wr_data_i
);

	localparam int NREGS = 2 ** riscv_pkg::REG_ADDR_W;

	// x1..x31 only, x0 has no storage
	logic [riscv_pkg::XLEN-1:0] regs_q [1:NREGS-1];

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			// writes to x0 dropped here
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	// combinational reads, x0 always zero
	always_comb begin
		rs1_data_o = '0;
		rs2_data_o = '0;
		if (rs1_addr_i != '0) begin
			rs1_data_o = regs_q[rs1_addr_i];
		end
		if (rs2_addr_i != '0) begin
			rs2_data_o = regs_q[rs2_addr_i];
		end
	end

	// hart never commits an unknown result
	a_wr_known: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		wr_en_i |-> !$isunknown({wr_addr_i, wr_data_i}));

endmodule

`default_nettype wire

/* source/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

	// --------------------
	// widths and reset values
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int STATE_W = 3;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// base opcodes of the supported subset
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct fields that are recognised
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;
	// only SYSTEM word accepted
	localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

	// address bits 31..28 of the peripheral window
	localparam logic [3:0] PERIPH_REGION = 4'hF;

	// --------------------
	// exception codes on exception_bus_o
	localparam logic [3:0] EXC_NONE = 4'd0;
	localparam logic [3:0] EXC_ILLEGAL = 4'd1;
	localparam logic [3:0] EXC_MISALIGNED_DATA = 4'd2;
	localparam logic [3:0] EXC_MISALIGNED_FETCH = 4'd3;
	localparam logic [3:0] EXC_BREAK = 4'd4;

	// hart sequencer states
	localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
	localparam logic [STATE_W-1:0] ST_FETCH = 3'd1;
	localparam logic [STATE_W-1:0] ST_DECODE = 3'd2;
	localparam logic [STATE_W-1:0] ST_EXECUTE = 3'd3;
	localparam logic [STATE_W-1:0] ST_MEMORY = 3'd4;
	localparam logic [STATE_W-1:0] ST_WRITEBACK = 3'd5;
	localparam logic [STATE_W-1:0] ST_HALT = 3'd6;

	// --------------------
	// instruction word views, opcode always in bits 6..0
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

endpackage

`default_nettype wire
